/* filelist.f */
+incdir+.
axi_pkg.sv
mem_pkg.sv
sram_req_if.sv
axi_write_slave.sv
axi_read_slave.sv
sram_arbiter.sv
sram_array.sv
axi_sram.sv
tb_clock.sv
axi_sram_checker.sv
tb_axi_sram.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_sram -f filelist.f -o tb_axi_sram
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_axi_sram +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* tb_axi_sram.sv */
`default_nettype none
`include "sram_cfg.svh"

module tb_axi_sram;
  import axi_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int REGION     = 'h100;
  localparam int SPAN       = 64;
  localparam int N_RAND     = 20;
  localparam int N_CONC     = 8;
  localparam int N_TRANS    = 8 + 2 * N_RAND + 2 * N_CONC + 2;
  localparam int TIMEOUT    = N_TRANS * 16 * 8 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD;

  logic      clk;
  logic      rst;
  logic      awvalid;
  axi_id_t   awid;
  axi_addr_t awaddr;
  axi_len_t  awlen;
  logic      awready;
  logic      wvalid;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wlast;
  logic      wready;
  logic      bvalid;
  axi_id_t   bid;
  axi_resp_t bresp;
  logic      bready;
  logic      arvalid;
  axi_id_t   arid;
  axi_addr_t araddr;
  axi_len_t  arlen;
  logic      arready;
  logic      rvalid;
  axi_data_t rdata;
  axi_id_t   rid;
  axi_resp_t rresp;
  logic      rlast;
  logic      rready;

  int         seed = 53;
  int         errors = 0;
  int         assert_fails;
  logic [7:0] model_mem [0:65535];

  tb_clock #(.PERIOD(CLK_PERIOD)) i_tb_clock (.clk(clk));

  axi_sram i_axi_sram (.*);

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t: %s got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  function automatic logic [31:0] model_word(input int word);
    logic [31:0] w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = model_mem[word * 4 + b];
    end
    return w;
  endfunction

  // 75 percent chance of ready in any cycle
  function automatic logic random_ready();
    return ($random(seed) & 3) != 0;
  endfunction

  task automatic write_burst(input int word, input int len, input bit full_strb);
    axi_id_t   id;
    axi_data_t data;
    axi_strb_t strb;
    id = axi_id_t'($random(seed));
    awvalid <= 1'b1;
    awid    <= id;
    awaddr  <= axi_addr_t'(word * 4);
    awlen   <= axi_len_t'(len);
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
    for (int beat = 0; beat <= len; beat++) begin
      data = $random(seed);
      strb = full_strb ? 4'hf : axi_strb_t'($random(seed));
      wvalid <= 1'b1;
      wdata  <= data;
      wstrb  <= strb;
      wlast  <= (beat == len);
      do @(posedge clk); while (!wready);
      // Model takes the beat at its W transfer
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          model_mem[(word + beat) * 4 + b] = data[8*b +: 8];
        end
      end
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    bready <= random_ready();
    @(posedge clk);
    while (!(bvalid && bready)) begin
      bready <= random_ready();
      @(posedge clk);
    end
    check(bid, id, "bid");
    check(bresp, RESP_OKAY, "bresp");
    bready <= 1'b0;
  endtask

  task automatic read_burst(input int word, input int len);
    axi_id_t id;
    int      beat;
    id = axi_id_t'($random(seed));
    arvalid <= 1'b1;
    arid    <= id;
    araddr  <= axi_addr_t'(word * 4);
    arlen   <= axi_len_t'(len);
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    rready  <= random_ready();
    beat = 0;
    while (beat <= len) begin
      @(posedge clk);
      if (rvalid && rready) begin
        check(rdata, model_word(word + beat), "rdata");
        check(rid, id, "rid");
        check(rresp, RESP_OKAY, "rresp");
        check(rlast, beat == len, "rlast");
        beat++;
      end
      rready <= random_ready();
    end
    rready <= 1'b0;
    @(posedge clk);
    check(rvalid, 1'b0, "rvalid after last beat");
  endtask

  task automatic random_write(input int base, input int span);
    int len;
    int off;
    len = $random(seed) & 15;
    off = ($random(seed) & 32'hffff) % (span - len);
    write_burst(base + off, len, 1'b0);
  endtask

  task automatic random_read(input int base, input int span);
    int len;
    int off;
    len = $random(seed) & 15;
    off = ($random(seed) & 32'hffff) % (span - len);
    read_burst(base + off, len);
  endtask

  initial begin
    #(TIMEOUT);
    $display("Timeout: a burst did not complete in time");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int len;
    int off;
    rst     = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    rready  = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    check(bvalid, 1'b0, "bvalid after reset");
    check(rvalid, 1'b0, "rvalid after reset");
    check(wready, 1'b0, "wready after reset");
    check(awready, 1'b1, "awready after reset");
    check(arready, 1'b1, "arready after reset");

    // Known data over the whole region
    for (int k = 0; k < SPAN / 16; k++) begin
      write_burst(REGION + 16 * k, 15, 1'b1);
    end
    for (int k = 0; k < SPAN / 16; k++) begin
      read_burst(REGION + 16 * k, 15);
    end

    // Partial strobes merged over known data, then read back
    for (int i = 0; i < N_RAND; i++) begin
      len = $random(seed) & 15;
      off = ($random(seed) & 32'hffff) % (SPAN - len);
      write_burst(REGION + off, len, 1'b0);
      read_burst(REGION + off, len);
    end

    // Lower half written while upper half is read
    fork
      for (int i = 0; i < N_CONC; i++) begin
        random_write(REGION, SPAN / 2);
      end
      for (int i = 0; i < N_CONC; i++) begin
        random_read(REGION + SPAN / 2, SPAN / 2);
      end
    join
    read_burst(REGION, 15);
    read_burst(REGION + 16, 15);

    assert_fails = i_axi_sram.i_axi_sram_checker.assert_fails;
    $display("Done: %0d check errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axi_sram_checker.sv */
`default_nettype none

module axi_sram_checker (
  input wire                     clk,
  input wire                     rst,
  input wire                     awready,
  input wire                     wready,
  input wire                     bvalid,
  input wire                     bready,
  input wire                     rvalid,
  input wire                     rready,
  input wire axi_pkg::axi_data_t rdata,
  input wire axi_pkg::axi_id_t   rid,
  input wire                     rlast,
  input wire                     wr_req,
  input wire                     wr_gnt,
  input wire                     rd_req,
  input wire                     rd_gnt
);

  int assert_fails = 0;

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst)
    bvalid && !bready |=> bvalid)
    else begin
      assert_fails++;
      $error("bvalid dropped before bready");
    end

  // Held beat must not change while stalled
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
    else begin
      assert_fails++;
      $error("R beat changed or dropped before rready");
    end

  a_one_grant: assert property (@(posedge clk) disable iff (!rst)
    !(wr_gnt && rd_gnt))
    else begin
      assert_fails++;
      $error("both SRAM grants high");
    end

  a_wr_gnt_req: assert property (@(posedge clk) disable iff (!rst)
    wr_gnt |-> wr_req)
    else begin
      assert_fails++;
      $error("write grant without request");
    end

  a_rd_gnt_req: assert property (@(posedge clk) disable iff (!rst)
    rd_gnt |-> rd_req)
    else begin
      assert_fails++;
      $error("read grant without request");
    end

  // Idle shows awready, response phase shows bvalid
  a_wready_phase: assert property (@(posedge clk) disable iff (!rst)
    wready |-> !awready && !bvalid)
    else begin
      assert_fails++;
      $error("wready outside the data phase");
    end

endmodule

bind axi_sram axi_sram_checker i_axi_sram_checker (
  .clk     (clk),
  .rst     (rst),
  .awready (awready),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rdata   (rdata),
  .rid     (rid),
  .rlast   (rlast),
  .wr_req  (wr_req.req),
  .wr_gnt  (wr_req.gnt),
  .rd_req  (rd_req.req),
  .rd_gnt  (rd_req.gnt)
);

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Free-running testbench clock
  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* axi_sram.sv */
`default_nettype none
`include "sram_cfg.svh"

module axi_sram (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      awvalid,
  input  wire  axi_pkg::axi_id_t   awid,
  input  wire  axi_pkg::axi_addr_t awaddr,
  input  wire  axi_pkg::axi_len_t  awlen,
  output logic                     awready,
  input  wire                      wvalid,
  input  wire  axi_pkg::axi_data_t wdata,
  input  wire  axi_pkg::axi_strb_t wstrb,
  input  wire                      wlast,
  output logic                     wready,
  output logic                     bvalid,
  output axi_pkg::axi_id_t         bid,
  output axi_pkg::axi_resp_t       bresp,
  input  wire                      bready,
  input  wire                      arvalid,
  input  wire  axi_pkg::axi_id_t   arid,
  input  wire  axi_pkg::axi_addr_t araddr,
  input  wire  axi_pkg::axi_len_t  arlen,
  output logic                     arready,
  output logic                     rvalid,
  output axi_pkg::axi_data_t       rdata,
  output axi_pkg::axi_id_t         rid,
  output axi_pkg::axi_resp_t       rresp,
  output logic                     rlast,
  input  wire                      rready
);
  import axi_pkg::*;
  import mem_pkg::*;

  logic       mem_en;
  logic       mem_we;
  word_addr_t mem_addr;
  axi_data_t  mem_wdata;
  byte_en_t   mem_be;
  axi_data_t  mem_rdata;

  sram_req_if wr_req ();
  sram_req_if rd_req ();

  axi_write_slave i_axi_write_slave (
    .clk     (clk),
    .rst     (rst),
    .awvalid (awvalid),
    .awid    (awid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .awready (awready),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wready  (wready),
    .bvalid  (bvalid),
    .bid     (bid),
    .bresp   (bresp),
    .bready  (bready),
    .mem     (wr_req.requester)
  );

  axi_read_slave i_axi_read_slave (
    .clk     (clk),
    .rst     (rst),
    .arvalid (arvalid),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rid     (rid),
    .rresp   (rresp),
    .rlast   (rlast),
    .rready  (rready),
    .mem     (rd_req.requester)
  );

  sram_arbiter i_sram_arbiter (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr_req.arbiter),
    .rd        (rd_req.arbiter),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_be    (mem_be),
    .mem_rdata (mem_rdata)
  );

  sram_array i_sram_array (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .be    (mem_be),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* sram_array.sv */
`default_nettype none
`include "sram_cfg.svh"

module sram_array (
  input  wire                      clk,
  input  wire                      en,
  input  wire                      we,
  input  wire  mem_pkg::word_addr_t addr,
  input  wire  axi_pkg::axi_data_t wdata,
  input  wire  mem_pkg::byte_en_t  be,
  output axi_pkg::axi_data_t       rdata
);
  import axi_pkg::*;

  axi_data_t mem [1 << `MEM_WORD_BITS];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        // Byte lanes written only where enabled
        for (int i = 0; i < `AXI_STRB_BITS; i++) begin
          if (be[i]) begin
            mem[addr][8*i +: 8] <= wdata[8*i +: 8];
          end
        end
      end else begin
        // Registered read, data out one cycle later
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

/* sram_arbiter.sv */
`default_nettype none
`include "sram_cfg.svh"

module sram_arbiter (
  input  wire                      clk,
  input  wire                      rst,
  sram_req_if.arbiter              wr,
  sram_req_if.arbiter              rd,
  output logic                     mem_en,
  output logic                     mem_we,
  output mem_pkg::word_addr_t      mem_addr,
  output axi_pkg::axi_data_t       mem_wdata,
  output mem_pkg::byte_en_t        mem_be,
  input  wire  axi_pkg::axi_data_t mem_rdata
);
  import mem_pkg::*;

  typedef enum req_sel_t {
    SEL_WR = 1'b0,
    SEL_RD = 1'b1
  } sel_e;

  sel_e last_win;

  // On a tie the requester that lost last time wins
  assign wr.gnt = wr.req && (!rd.req || (last_win == SEL_RD));
  assign rd.gnt = rd.req && (!wr.req || (last_win == SEL_WR));

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      last_win <= SEL_RD;
    end else if (wr.gnt) begin
      last_win <= SEL_WR;
    end else if (rd.gnt) begin
      last_win <= SEL_RD;
    end
  end

  assign mem_en = wr.gnt || rd.gnt;

  always_comb begin
    if (rd.gnt) begin
      mem_we    = rd.we;
      mem_addr  = rd.addr;
      mem_wdata = rd.wdata;
      mem_be    = rd.be;
    end else begin
      mem_we    = wr.we;
      mem_addr  = wr.addr;
      mem_wdata = wr.wdata;
      mem_be    = wr.be;
    end
  end

  // Read data goes to both, only the read engine samples it
  assign rd.rdata = mem_rdata;
  assign wr.rdata = mem_rdata;

endmodule

`default_nettype wire

/* axi_read_slave.sv */
`default_nettype none
`include "sram_cfg.svh"

module axi_read_slave (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      arvalid,
  input  wire  axi_pkg::axi_id_t   arid,
  input  wire  axi_pkg::axi_addr_t araddr,
  input  wire  axi_pkg::axi_len_t  arlen,
  output logic                     arready,
  output logic                     rvalid,
  output axi_pkg::axi_data_t       rdata,
  output axi_pkg::axi_id_t         rid,
  output axi_pkg::axi_resp_t       rresp,
  output logic                     rlast,
  input  wire                      rready,
  sram_req_if.requester            mem
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic {
    RD_IDLE,
    RD_BUSY
  } rd_state_e;

  rd_state_e              state;
  axi_id_t                id_q;
  axi_len_t               len_q;
  axi_len_t               beat_cnt;
  logic [`AXI_LEN_BITS:0] issue_cnt;
  word_addr_t             raddr;
  logic                   in_flight;
  axi_data_t              buf_q [2];
  logic                   wr_ptr;
  logic                   rd_ptr;
  logic [1:0]             buf_cnt;
  logic [1:0]             occupancy;
  logic                   ar_fire;
  logic                   r_fire;

  assign ar_fire   = arvalid && arready;
  assign r_fire    = rvalid && rready;
  assign occupancy = buf_cnt + {1'b0, in_flight};

  assign arready = (state == RD_IDLE);
  assign rvalid  = (buf_cnt != 2'd0);
  assign rdata   = buf_q[rd_ptr];
  assign rid     = id_q;
  assign rresp   = RESP_OKAY;
  assign rlast   = (beat_cnt == len_q);

  // Only issue while a buffer slot is guaranteed for the returning word
  assign mem.req   = (state == RD_BUSY) && (issue_cnt <= {1'b0, len_q}) &&
                     (occupancy < 2'd2);
  assign mem.we    = 1'b0;
  assign mem.addr  = raddr;
  assign mem.wdata = '0;
  assign mem.be    = '0;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state     <= RD_IDLE;
      len_q     <= '0;
      beat_cnt  <= '0;
      issue_cnt <= '0;
      in_flight <= 1'b0;
    end else begin
      in_flight <= mem.req && mem.gnt;
      case (state)
        RD_IDLE: begin
          if (ar_fire) begin
            state     <= RD_BUSY;
            len_q     <= arlen;
            beat_cnt  <= '0;
            issue_cnt <= '0;
          end
        end
        default: begin
          if (mem.gnt) begin
            issue_cnt <= issue_cnt + 1'b1;
          end
          if (r_fire) begin
            if (rlast) begin
              state <= RD_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Two-entry return buffer
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      buf_cnt <= 2'd0;
      wr_ptr  <= 1'b0;
      rd_ptr  <= 1'b0;
    end else begin
      if (in_flight) begin
        wr_ptr <= ~wr_ptr;
      end
      if (r_fire) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({in_flight, r_fire})
        2'b10:   buf_cnt <= buf_cnt + 2'd1;
        2'b01:   buf_cnt <= buf_cnt - 2'd1;
        default: buf_cnt <= buf_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (in_flight) begin
      buf_q[wr_ptr] <= mem.rdata;
    end
    if (ar_fire) begin
      id_q  <= arid;
      raddr <= araddr[`MEM_WORD_BITS+1:2];
    end else if (mem.gnt) begin
      raddr <= raddr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* axi_write_slave.sv */
`default_nettype none
`include "sram_cfg.svh"

module axi_write_slave (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      awvalid,
  input  wire  axi_pkg::axi_id_t   awid,
  input  wire  axi_pkg::axi_addr_t awaddr,
  input  wire  axi_pkg::axi_len_t  awlen,
  output logic                     awready,
  input  wire                      wvalid,
  input  wire  axi_pkg::axi_data_t wdata,
  input  wire  axi_pkg::axi_strb_t wstrb,
  input  wire                      wlast,
  output logic                     wready,
  output logic                     bvalid,
  output axi_pkg::axi_id_t         bid,
  output axi_pkg::axi_resp_t       bresp,
  input  wire                      bready,
  sram_req_if.requester            mem
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e  state;
  axi_id_t    id_q;
  word_addr_t waddr;
  logic       aw_fire;
  logic       b_fire;

  assign aw_fire = awvalid && awready;
  assign b_fire  = bvalid && bready;

  assign awready = (state == WR_IDLE);
  assign bvalid  = (state == WR_RESP);
  assign bid     = id_q;
  assign bresp   = RESP_OKAY;

  // One strobed word write per W beat, the grant accepts the beat
  assign mem.req   = (state == WR_DATA) && wvalid;
  assign mem.we    = 1'b1;
  assign mem.addr  = waddr;
  assign mem.wdata = wdata;
  assign mem.be    = wstrb;
  assign wready    = mem.gnt;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      state <= WR_IDLE;
    end else begin
      case (state)
        WR_IDLE: begin
          if (aw_fire) begin
            state <= WR_DATA;
          end
        end
        WR_DATA: begin
          // Burst ends on wlast, length is not counted
          if (mem.gnt && wlast) begin
            state <= WR_RESP;
          end
        end
        default: begin
          if (b_fire) begin
            state <= WR_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q  <= awid;
      waddr <= awaddr[`MEM_WORD_BITS+1:2];
    end else if (mem.gnt) begin
      waddr <= waddr + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sram_req_if.sv */
`default_nettype none
`include "sram_cfg.svh"

interface sram_req_if;
  import axi_pkg::*;
  import mem_pkg::*;

  // Access takes place when req and gnt are both high
  logic       req;
  logic       we;
  word_addr_t addr;
  axi_data_t  wdata;
  byte_en_t   be;

  logic       gnt;
  // Read data, valid the cycle after the grant
  axi_data_t  rdata;

  modport requester (
    output req, we, addr, wdata, be,
    input  gnt, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata, be,
    output gnt, rdata
  );

endinterface

`default_nettype wire

/* mem_pkg.sv */
`default_nettype none
`include "sram_cfg.svh"

package mem_pkg;

  typedef logic [`MEM_WORD_BITS-1:0] word_addr_t;
  typedef logic [`AXI_STRB_BITS-1:0] byte_en_t;

  // 0 is the write engine, 1 the read engine
  typedef logic                      req_sel_t;

endpackage

`default_nettype wire

/* axi_pkg.sv */
`default_nettype none
`include "sram_cfg.svh"

package axi_pkg;

  typedef logic [`AXI_ID_BITS-1:0]   axi_id_t;
  typedef logic [`AXI_LEN_BITS-1:0]  axi_len_t;
  typedef logic [`AXI_ADDR_BITS-1:0] axi_addr_t;
  typedef logic [`AXI_DATA_BITS-1:0] axi_data_t;
  typedef logic [`AXI_STRB_BITS-1:0] axi_strb_t;
  typedef logic [1:0]                axi_resp_t;

  // Only OKAY is ever returned
  localparam axi_resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

/* sram_cfg.svh */
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// AXI channel widths
`define AXI_ID_BITS   4
`define AXI_LEN_BITS  4
`define AXI_ADDR_BITS 16
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4

// Word index into the SRAM, taken from byte address bits 15:2
`define MEM_WORD_BITS 14

`endif
